// ==== src/board_pkg.sv ====
// board_pkg: address map, register offsets, channel count, build identity, setpoint array type
package board_pkg;

    // ------------------------------------------------------------
    // address map
    // ------------------------------------------------------------

    // addr[15:12] selects the board register space
    localparam logic [3:0] ADDR_MAIN = 4'h0;

    // motor channels, channel n lives at addr[7:4] == n
    localparam int NUM_CHAN = 4;

    // main board registers, addr[7:4] == 0
    localparam logic [3:0] REG_STATUS   = 4'd0;   // reboot request on write
    localparam logic [3:0] REG_PHYCTRL  = 4'd1;   // phy request word, readback only
    localparam logic [3:0] REG_PHYDATA  = 4'd2;   // phy register data
    localparam logic [3:0] REG_TIMEOUT  = 4'd3;   // led select + watchdog period
    localparam logic [3:0] REG_FVERSION = 4'd4;   // firmware version
    localparam logic [3:0] REG_GIT_DESC = 4'd5;   // git describe word

    // per-channel registers, addr[7:4] == channel
    localparam logic [3:0] CREG_DAC  = 4'd0;      // dac setpoint
    localparam logic [3:0] CREG_CTRL = 4'd1;      // amplifier enable

    // ------------------------------------------------------------
    // build identity
    // ------------------------------------------------------------

    localparam logic [31:0] FW_VERSION = 32'd8;
    localparam logic [27:0] GIT_SHA    = 28'h3a91c7e;   // abbreviated commit hash
    localparam logic        GIT_DIRTY  = 1'b0;          // uncommitted changes in build tree

    // commits past the tag, and the version named by that tag
    localparam int GIT_COMMITS    = 12;
    localparam int GIT_FW_VERSION = 8;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------

    // one 16-bit dac setpoint per channel, index 0 is channel 1
    typedef logic [15:0] chan_word_t [NUM_CHAN];

endpackage

// ==== src/wdog_pkg.sv ====
// wdog_pkg: watchdog counter width, default period, phase limits, status codes
package wdog_pkg;

    // counter width, upper 16 bits compare against the period
    localparam int WDOG_CNT_W = 24;

    // period after reset, 0x1680 ticks of 256 clocks (about 30 ms)
    localparam logic [15:0] WDOG_PERIOD_RST = 16'h1680;

    // upper bounds of the status phases, inclusive
    localparam logic [15:0] WDOG_LIM1 = 16'h2580;   // ~50 ms
    localparam logic [15:0] WDOG_LIM2 = 16'h4B00;   // ~100 ms
    localparam logic [15:0] WDOG_LIM3 = 16'h7080;   // ~150 ms
    localparam logic [15:0] WDOG_LIM4 = 16'h9600;   // ~200 ms

    // period class shown on the led
    typedef enum logic [2:0] {
        WDOG_DISABLE     = 3'd0,   // period 0, no watchdog
        WDOG_PHASE_ONE   = 3'd1,
        WDOG_PHASE_TWO   = 3'd2,
        WDOG_PHASE_THREE = 3'd3,
        WDOG_PHASE_FOUR  = 3'd4,
        WDOG_PHASE_FIVE  = 3'd5    // beyond the last limit
    } wdog_status_t;

endpackage

// ==== src/reg_bus_if.sv ====
// reg_bus_if: host register bus with read/write address ports, regfile and listen modports
`timescale 1ns/1ps

interface reg_bus_if;

    logic [15:0] raddr;   // read address, read data follows combinationally
    logic [15:0] waddr;   // write address
    logic [31:0] wdata;   // write data
    logic        wen;     // single-cycle write strobe, always accepted
    logic [31:0] rdata;   // read data back to host

    // register file that owns the read data
    modport regfile (
        input  raddr,
        input  waddr,
        input  wdata,
        input  wen,
        output rdata
    );

    // block that decodes the bus but returns data another way
    modport listen (
        input  raddr,
        input  waddr,
        input  wdata,
        input  wen
    );

endinterface

// ==== src/board_regs.sv ====
// board_regs: main board register file, read mux and git description word
`timescale 1ns/1ps

module board_regs (
    input  logic             sysclk,
    input  logic             reset,
    reg_bus_if.regfile       bus,
    input  logic [31:0]      chan_rdata,        // read data from the channel registers
    output logic [15:0]      wdog_period,       // watchdog period, host writable
    output logic             wdog_period_led,   // led shows period status when set
    output logic             reboot             // fpga reboot request
);

    import board_pkg::*;
    import wdog_pkg::*;

    logic [15:0] phy_ctrl;      // phy request word, kept for readback
    logic [15:0] phy_data;      // phy register transfer data
    logic        write_main;    // write strobe decoded to the main space
    logic        git_commits_nz;
    logic [1:0]  git_rel;       // firmware version against git tag version
    logic [31:0] git_desc;
    logic [31:0] rdata_mux;

    // ------------------------------------------------------------
    // git describe word
    // ------------------------------------------------------------

    assign git_commits_nz = (GIT_COMMITS != 0);   // commits past the tag

    // 0: same as tag, 1: one release ahead (preview)
    // 2: further ahead, 3: behind the tag
    always_comb begin
        if (FW_VERSION == 32'(GIT_FW_VERSION))
            git_rel = 2'd0;
        else if (FW_VERSION == 32'(GIT_FW_VERSION + 1))
            git_rel = 2'd1;
        else if (FW_VERSION > 32'(GIT_FW_VERSION + 1))
            git_rel = 2'd2;
        else
            git_rel = 2'd3;
    end

    assign git_desc = {GIT_SHA, GIT_DIRTY, git_commits_nz, git_rel};

    // ------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------

    assign write_main = bus.wen && (bus.waddr[15:12] == ADDR_MAIN)
                        && (bus.waddr[7:4] == 4'd0);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            reboot          <= 1'b0;
            phy_ctrl        <= 16'd0;
            phy_data        <= 16'd0;
            wdog_period     <= WDOG_PERIOD_RST;
            wdog_period_led <= 1'b0;
        end else if (write_main) begin
            case (bus.waddr[3:0])
                REG_STATUS:  reboot   <= bus.wdata[21] ? bus.wdata[20] : 1'b0;   // [21] arms
                REG_PHYCTRL: phy_ctrl <= bus.wdata[15:0];
                REG_PHYDATA: phy_data <= bus.wdata[15:0];
                REG_TIMEOUT: begin
                    wdog_period_led <= bus.wdata[31];     // led select
                    wdog_period     <= bus.wdata[15:0];   // 0 turns the watchdog off
                end
                default: ;                                // read-only offsets
            endcase
        end
    end

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------

    // anything outside the main offsets goes to the channel registers
    always_comb begin
        rdata_mux = chan_rdata;
        if (bus.raddr[7:4] == 4'd0) begin
            case (bus.raddr[3:0])
                REG_PHYCTRL:  rdata_mux = {16'd0, phy_ctrl};
                REG_PHYDATA:  rdata_mux = {16'd0, phy_data};
                REG_TIMEOUT:  rdata_mux = {wdog_period_led, 15'd0, wdog_period};
                REG_FVERSION: rdata_mux = FW_VERSION;
                REG_GIT_DESC: rdata_mux = git_desc;
                default:      rdata_mux = chan_rdata;
            endcase
        end
    end

    assign bus.rdata = rdata_mux;

endmodule

// ==== src/wdog_timer.sv ====
// wdog_timer: host-silence counter, timeout flag and period phase classifier
`timescale 1ns/1ps

module wdog_timer (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  wdog_clear,           // drops the timeout, e.g. on powerup
    input  logic                  reg_wen,              // any host write restarts the count
    input  logic [15:0]           wdog_period,          // in units of 256 clocks
    output logic                  wdog_timeout,         // host went silent for a period
    output wdog_pkg::wdog_status_t wdog_period_status   // period class for the led
);

    import wdog_pkg::*;

    logic [WDOG_CNT_W-1:0] wdog_count;   // clocks since the last write
    logic [15:0]           wdog_ticks;   // count / 256

    assign wdog_ticks = wdog_count[WDOG_CNT_W-1 -: 16];

    // ------------------------------------------------------------
    // counter and flag
    // ------------------------------------------------------------

    // count stops once it reaches the period, flag sets on the next edge
    always_ff @(posedge sysclk) begin
        if (reset || wdog_clear) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (reg_wen) begin
            wdog_count <= '0;                           // host is alive
        end else if (wdog_period != 16'd0) begin        // period 0 disables
            if (wdog_ticks == wdog_period)
                wdog_timeout <= 1'b1;                   // held until reset or clear
            else
                wdog_count <= wdog_count + WDOG_CNT_W'(1);
        end
    end

    // ------------------------------------------------------------
    // period phase
    // ------------------------------------------------------------

    always_comb begin
        if (wdog_period == 16'd0)
            wdog_period_status = WDOG_DISABLE;
        else if (wdog_period <= WDOG_LIM1)
            wdog_period_status = WDOG_PHASE_ONE;      // up to ~50 ms
        else if (wdog_period <= WDOG_LIM2)
            wdog_period_status = WDOG_PHASE_TWO;
        else if (wdog_period <= WDOG_LIM3)
            wdog_period_status = WDOG_PHASE_THREE;
        else if (wdog_period <= WDOG_LIM4)
            wdog_period_status = WDOG_PHASE_FOUR;     // up to ~200 ms
        else
            wdog_period_status = WDOG_PHASE_FIVE;
    end

endmodule

// ==== src/chan_regs.sv ====
// chan_regs: per-channel dac setpoint and amp enable registers, timeout shutdown, read data
`timescale 1ns/1ps

module chan_regs (
    input  logic                        sysclk,
    input  logic                        reset,
    reg_bus_if.listen                   bus,
    input  logic                        wdog_timeout,   // forces all enables off
    output logic [31:0]                 chan_rdata,     // 0 outside the channel space
    output board_pkg::chan_word_t       dac_setpoint,
    output logic [board_pkg::NUM_CHAN-1:0] amp_enable
);

    import board_pkg::*;

    logic wr_chan;   // write strobe hits a channel address
    logic rd_chan;   // read address is a channel address

    assign wr_chan = bus.wen && (bus.waddr[15:12] == ADDR_MAIN)
                     && (bus.waddr[7:4] >= 4'd1) && (bus.waddr[7:4] <= 4'(NUM_CHAN));
    assign rd_chan = (bus.raddr[15:12] == ADDR_MAIN)
                     && (bus.raddr[7:4] >= 4'd1) && (bus.raddr[7:4] <= 4'(NUM_CHAN));

    // ------------------------------------------------------------
    // setpoint and enable registers
    // ------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < NUM_CHAN; i++)
                dac_setpoint[i] <= 16'd0;
            amp_enable <= '0;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (wr_chan && (bus.waddr[7:4] == 4'(i + 1))) begin   // channel i+1
                    if (bus.waddr[3:0] == CREG_DAC)
                        dac_setpoint[i] <= bus.wdata[15:0];
                    if (bus.waddr[3:0] == CREG_CTRL && !wdog_timeout)
                        amp_enable[i] <= bus.wdata[0];              // locked out on timeout
                end
            end
            if (wdog_timeout)
                amp_enable <= '0;                                   // safety shutdown
        end
    end

    // read data, timeout mirrored in bit 31 of the control word
    always_comb begin
        chan_rdata = 32'd0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (rd_chan && (bus.raddr[7:4] == 4'(i + 1))) begin
                if (bus.raddr[3:0] == CREG_DAC)
                    chan_rdata = {16'd0, dac_setpoint[i]};
                else if (bus.raddr[3:0] == CREG_CTRL)
                    chan_rdata = {wdog_timeout, 30'd0, amp_enable[i]};
            end
        end
    end

endmodule

// ==== src/board_ctrl_top.sv ====
// board_ctrl_top: host bus ports onto the register bus, board regs, watchdog and channel regs
`timescale 1ns/1ps

module board_ctrl_top (
    input  logic                           sysclk,
    input  logic                           reset,
    input  logic [15:0]                    reg_raddr,
    input  logic [15:0]                    reg_waddr,
    input  logic [31:0]                    reg_wdata,
    input  logic                           reg_wen,
    input  logic                           wdog_clear,
    output logic [31:0]                    reg_rdata,          // combinational from reg_raddr
    output logic                           reboot,
    output logic                           wdog_timeout,
    output logic                           wdog_period_led,
    output wdog_pkg::wdog_status_t         wdog_period_status,
    output board_pkg::chan_word_t          dac_setpoint,
    output logic [board_pkg::NUM_CHAN-1:0] amp_enable
);

    logic [31:0] chan_rdata;    // channel read data into the main mux
    logic [15:0] wdog_period;   // stored period to the watchdog

    // ------------------------------------------------------------
    // host bus
    // ------------------------------------------------------------

    reg_bus_if bus ();

    assign bus.raddr = reg_raddr;
    assign bus.waddr = reg_waddr;
    assign bus.wdata = reg_wdata;
    assign bus.wen   = reg_wen;
    assign reg_rdata = bus.rdata;   // board_regs owns the read data

    // ------------------------------------------------------------
    // blocks
    // ------------------------------------------------------------

    board_regs u_board_regs (
        .sysclk          (sysclk),
        .reset           (reset),
        .bus             (bus.regfile),
        .chan_rdata      (chan_rdata),
        .wdog_period     (wdog_period),
        .wdog_period_led (wdog_period_led),
        .reboot          (reboot)
    );

    wdog_timer u_wdog_timer (
        .sysclk             (sysclk),
        .reset              (reset),
        .wdog_clear         (wdog_clear),
        .reg_wen            (reg_wen),
        .wdog_period        (wdog_period),
        .wdog_timeout       (wdog_timeout),
        .wdog_period_status (wdog_period_status)
    );

    chan_regs u_chan_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus          (bus.listen),
        .wdog_timeout (wdog_timeout),
        .chan_rdata   (chan_rdata),
        .dac_setpoint (dac_setpoint),
        .amp_enable   (amp_enable)
    );

endmodule

// ==== include/board_ctrl_vectors.svh ====
// register step type, main register addresses and the table of write/read steps
`ifndef BOARD_CTRL_VECTORS_SVH
`define BOARD_CTRL_VECTORS_SVH

// one host access, outputs are only checked on read steps
typedef struct packed {
    logic        wr;           // 1 write, 0 read and check
    logic [15:0] addr;
    logic [31:0] data;         // write data, unused on reads
    logic [31:0] exp_rdata;    // expected reg_rdata
    logic        exp_led;      // expected wdog_period_led
    logic [2:0]  exp_status;   // expected wdog_period_status
    logic        exp_reboot;
} reg_step_t;

// main space addresses, addr[7:4] == 0
localparam logic [15:0] A_STATUS   = {ADDR_MAIN, 8'h00, REG_STATUS};
localparam logic [15:0] A_PHYCTRL  = {ADDR_MAIN, 8'h00, REG_PHYCTRL};
localparam logic [15:0] A_PHYDATA  = {ADDR_MAIN, 8'h00, REG_PHYDATA};
localparam logic [15:0] A_TIMEOUT  = {ADDR_MAIN, 8'h00, REG_TIMEOUT};
localparam logic [15:0] A_FVERSION = {ADDR_MAIN, 8'h00, REG_FVERSION};
localparam logic [15:0] A_GIT_DESC = {ADDR_MAIN, 8'h00, REG_GIT_DESC};

// channel 5 is past the last channel, channel 1 must stay untouched by it
localparam logic [15:0] A_CH5_DAC  = {ADDR_MAIN, 4'h0, 4'd5, CREG_DAC};
localparam logic [15:0] A_CH5_CTRL = {ADDR_MAIN, 4'h0, 4'd5, CREG_CTRL};
localparam logic [15:0] A_CH1_DAC  = {ADDR_MAIN, 4'h0, 4'd1, CREG_DAC};
localparam logic [15:0] A_CH1_CTRL = {ADDR_MAIN, 4'h0, 4'd1, CREG_CTRL};

localparam int NUM_STEPS = 28;

localparam reg_step_t STEPS [NUM_STEPS] = '{
    //  wr    addr        data          exp_rdata     led   status            reboot
    '{1'b0, A_TIMEOUT,  32'h0,        32'h00001680, 1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_FVERSION, 32'h0,        FW_VERSION,   1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b1, A_PHYCTRL,  32'hABCD1234, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_PHYCTRL,  32'h0,        32'h00001234, 1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b1, A_PHYDATA,  32'h5555BEEF, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_PHYDATA,  32'h0,        32'h0000BEEF, 1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b1, A_TIMEOUT,  32'h80000000, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_TIMEOUT,  32'h0,        32'h80000000, 1'b1, WDOG_DISABLE,     1'b0},
    '{1'b1, A_TIMEOUT,  32'h00002580, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_TIMEOUT,  32'h0,        32'h00002580, 1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b1, A_TIMEOUT,  32'h7FFF2581, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_TIMEOUT,  32'h0,        32'h00002581, 1'b0, WDOG_PHASE_TWO,   1'b0},
    '{1'b1, A_TIMEOUT,  32'h80009600, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_TIMEOUT,  32'h0,        32'h80009600, 1'b1, WDOG_PHASE_FOUR,  1'b0},
    '{1'b1, A_TIMEOUT,  32'h00009601, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_TIMEOUT,  32'h0,        32'h00009601, 1'b0, WDOG_PHASE_FIVE,  1'b0},
    '{1'b1, A_STATUS,   32'h00300000, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_STATUS,   32'h0,        32'h00000000, 1'b0, WDOG_PHASE_FIVE,  1'b1},
    '{1'b1, A_STATUS,   32'h00100000, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_STATUS,   32'h0,        32'h00000000, 1'b0, WDOG_PHASE_FIVE,  1'b0},
    '{1'b1, A_CH5_DAC,  32'h0000FFFF, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b1, A_CH5_CTRL, 32'h00000001, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_CH5_DAC,  32'h0,        32'h00000000, 1'b0, WDOG_PHASE_FIVE,  1'b0},
    '{1'b0, A_CH5_CTRL, 32'h0,        32'h00000000, 1'b0, WDOG_PHASE_FIVE,  1'b0},
    '{1'b0, A_CH1_DAC,  32'h0,        32'h00000000, 1'b0, WDOG_PHASE_FIVE,  1'b0},
    '{1'b0, A_CH1_CTRL, 32'h0,        32'h00000000, 1'b0, WDOG_PHASE_FIVE,  1'b0},
    '{1'b1, A_TIMEOUT,  32'h00001680, 32'h0,        1'b0, WDOG_PHASE_ONE,   1'b0},
    '{1'b0, A_TIMEOUT,  32'h0,        32'h00001680, 1'b0, WDOG_PHASE_ONE,   1'b0}
};

`endif

// ==== tests/board_ctrl_tb.sv ====
// board_ctrl_tb: testbench for board_ctrl_top with table steps, channel, watchdog and clear runs
`timescale 1ns/1ps

module board_ctrl_tb;

    import board_pkg::*;
    import wdog_pkg::*;

    `include "board_ctrl_vectors.svh"

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int ALIVE_GAP     = 300;    // host write spacing, below 2*256
    localparam int ALIVE_WRITES  = 4;
    localparam int SILENT_CYCLES = 2000;   // idle run with the watchdog off

    // rough length of all runs, the watchdog allows half again
    localparam int RUN_CYCLES = RESET_CYCLES + 2 * NUM_STEPS + 8 * NUM_CHAN
                                + ALIVE_WRITES * (ALIVE_GAP + 2) + 530 + SILENT_CYCLES + 40;
    localparam int LIMIT_CYCLES = RUN_CYCLES * 3 / 2;

    logic                sysclk;
    logic                reset;
    logic [15:0]         reg_raddr;
    logic [15:0]         reg_waddr;
    logic [31:0]         reg_wdata;
    logic                reg_wen;
    logic                wdog_clear;
    logic [31:0]         reg_rdata;
    logic                reboot;
    logic                wdog_timeout;
    logic                wdog_period_led;
    wdog_status_t        wdog_period_status;
    chan_word_t          dac_setpoint;
    logic [NUM_CHAN-1:0] amp_enable;

    int          errors;
    int          checks;
    logic [15:0] sp_model [NUM_CHAN];   // setpoints as written by the host

    board_ctrl_top UUT (
        .sysclk             (sysclk),
        .reset              (reset),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .wdog_clear         (wdog_clear),
        .reg_rdata          (reg_rdata),
        .reboot             (reboot),
        .wdog_timeout       (wdog_timeout),
        .wdog_period_led    (wdog_period_led),
        .wdog_period_status (wdog_period_status),
        .dac_setpoint       (dac_setpoint),
        .amp_enable         (amp_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(negedge sysclk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge sysclk);   // one strobe, taken at the rising edge in between
        reg_wen   = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        @(negedge sysclk);
        reg_raddr = addr;
        #1;                  // combinational read settles well before the next edge
        data = reg_rdata;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    function automatic logic [15:0] chan_addr(input int ch, input logic [3:0] off);
        return {ADDR_MAIN, 4'h0, 4'(ch), off};
    endfunction

    // sha, dirty, commits past tag, firmware against tag version
    function automatic logic [31:0] expected_git_word();
        logic [1:0] rel;
        if (int'(FW_VERSION) == GIT_FW_VERSION)
            rel = 2'd0;
        else if (int'(FW_VERSION) == GIT_FW_VERSION + 1)
            rel = 2'd1;
        else if (int'(FW_VERSION) > GIT_FW_VERSION + 1)
            rel = 2'd2;
        else
            rel = 2'd3;
        return {GIT_SHA, GIT_DIRTY, GIT_COMMITS != 0, rel};
    endfunction

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        logic [31:0] rd;
        logic [31:0] rnd;
        reg_step_t   step;
        reset      = 1'b1;
        reg_raddr  = 16'h0;
        reg_waddr  = 16'h0;
        reg_wdata  = 32'h0;
        reg_wen    = 1'b0;
        wdog_clear = 1'b0;
        errors     = 0;
        checks     = 0;
        void'($urandom(15));   // fixed seed for the setpoint data
        repeat (RESET_CYCLES) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        // identity and reset state
        read_reg(A_GIT_DESC, rd);
        check_word(rd, expected_git_word(), "git description");
        check_word(32'(wdog_timeout), 32'h0, "timeout after reset");
        check_word(32'(amp_enable), 32'h0, "enables after reset");

        // main registers, reboot and channel 5 from the table
        for (int i = 0; i < NUM_STEPS; i++) begin
            step = STEPS[i];
            if (step.wr) begin
                write_reg(step.addr, step.data);
            end else begin
                read_reg(step.addr, rd);
                check_word(rd, step.exp_rdata, $sformatf("step %0d read data", i));
                check_word(32'(wdog_period_led), 32'(step.exp_led), $sformatf("step %0d led", i));
                check_word(32'(wdog_period_status), 32'(step.exp_status),
                           $sformatf("step %0d status", i));
                check_word(32'(reboot), 32'(step.exp_reboot), $sformatf("step %0d reboot", i));
            end
        end

        // channel 5 writes in the table reach no channel
        check_word(32'(amp_enable), 32'h0, "enables after channel 5 writes");
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            check_word(32'(dac_setpoint[ch-1]), 32'h0,
                       $sformatf("ch%0d dac_setpoint after channel 5 writes", ch));
        end

        // ------------------------------------------------------------
        // channel registers
        // ------------------------------------------------------------
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            rnd = $urandom;
            sp_model[ch-1] = rnd[15:0];   // upper half must be dropped
            write_reg(chan_addr(ch, CREG_DAC), rnd);
            write_reg(chan_addr(ch, CREG_CTRL), 32'h1);
        end
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            read_reg(chan_addr(ch, CREG_DAC), rd);
            check_word(rd, {16'd0, sp_model[ch-1]}, $sformatf("ch%0d setpoint read", ch));
            check_word(32'(dac_setpoint[ch-1]), 32'(sp_model[ch-1]),
                       $sformatf("ch%0d dac_setpoint", ch));
            read_reg(chan_addr(ch, CREG_CTRL), rd);
            check_word(rd, 32'h1, $sformatf("ch%0d control read", ch));
        end
        check_word(32'(amp_enable), 32'({NUM_CHAN{1'b1}}), "enables after writes");

        // ------------------------------------------------------------
        // watchdog, period 2 means 512 silent clocks
        // ------------------------------------------------------------
        write_reg(A_TIMEOUT, 32'h2);
        for (int k = 0; k < ALIVE_WRITES; k++) begin
            idle(ALIVE_GAP);
            check_word(32'(wdog_timeout), 32'h0, $sformatf("timeout with host alive %0d", k));
            write_reg(A_PHYDATA, 32'(k));
        end
        idle(511);
        check_word(32'(wdog_timeout), 32'h0, "timeout 511 cycles after last write");
        idle(3);
        check_word(32'(wdog_timeout), 32'h1, "timeout 514 cycles after last write");
        idle(1);
        check_word(32'(amp_enable), 32'h0, "enables after timeout");
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            read_reg(chan_addr(ch, CREG_CTRL), rd);
            check_word(rd, 32'h80000000, $sformatf("ch%0d control during timeout", ch));
        end
        write_reg(chan_addr(1, CREG_CTRL), 32'h1);   // locked out
        check_word(32'(amp_enable), 32'h0, "enable write during timeout");

        // clear, re-enable, then period 0
        @(negedge sysclk);
        wdog_clear = 1'b1;
        @(negedge sysclk);
        wdog_clear = 1'b0;
        check_word(32'(wdog_timeout), 32'h0, "timeout after clear");
        write_reg(chan_addr(1, CREG_CTRL), 32'h1);
        check_word(32'(amp_enable[0]), 32'h1, "ch1 enable after clear");
        write_reg(A_TIMEOUT, 32'h0);
        check_word(32'(wdog_period_status), 32'(WDOG_DISABLE), "status with period 0");
        idle(SILENT_CYCLES);
        check_word(32'(wdog_timeout), 32'h0, "timeout with period 0");
        check_word(32'(amp_enable[0]), 32'h1, "ch1 enable with period 0");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // ------------------------------------------------------------
    // run limit
    // ------------------------------------------------------------

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Simulation did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
src/board_pkg.sv
src/wdog_pkg.sv
src/reg_bus_if.sv
src/board_regs.sv
src/wdog_timer.sv
src/chan_regs.sv
src/board_ctrl_top.sv
tests/board_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the board_ctrl testbench with verilator, run it and search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module board_ctrl_tb -o board_ctrl_sim \
    && ./obj_dir/board_ctrl_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
exit 0
